// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --assert --timing
TOP = tb_obstacle
FILELIST = filelist.f
BIN = obj_dir/V$(TOP)
LOG = sim.log
SRCS = $(filter-out +%,$(shell cat $(FILELIST))) hw/obstacle_defs.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
+incdir+hw
hw/obstacle_pkg.sv
hw/kindLfsr.sv
hw/wbRegFile.sv
hw/cactusMover.sv
hw/spriteAddrGen.sv
hw/obstacleTop.sv
tests/obstacleTop_sva.sv
tests/obstacleChecker.sv
tests/tb_obstacle.sv

// File: hw/cactusMover.sv
`include "obstacle_defs.svh"

module cactusMover
	import obstacle_pkg::*;
(
	input logic frame_Clk,
	input logic Reset,
	input ctrl_t ctrl,
	output obstacleState_t state
);

	coord_t posX;
	cactusKind_t kind;
	lfsr_t rnd;
	cactusKind_t randKind;
	cactusKind_t nextKind;
	coord_t sizeXc;
	coord_t stepX;
	logic respawn;

	kindLfsr lfsr_i
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.value(rnd)
	);

	// size, ground row and rom base all follow from the kind
	always_comb
	begin
		state.posX = posX;
		state.kind = kind;
		case (kind)
			Large1, Large2, Large3:
			begin
				state.posY = coord_t'(`GROUND_LARGE);
				state.sizeY = pixel_t'(`LARGE_H);
			end
			Small1, Small2, Small3:
			begin
				state.posY = coord_t'(`GROUND_SMALL);
				state.sizeY = pixel_t'(`SMALL_H);
			end
			default:
			begin
				state.posY = coord_t'(`HIDE_ROW);
				state.sizeY = '0;
			end
		endcase
		case (kind)
			Large1: state.sizeX = pixel_t'(`W_LARGE1);
			Large2: state.sizeX = pixel_t'(`W_LARGE2);
			Large3: state.sizeX = pixel_t'(`W_LARGE3);
			Small1: state.sizeX = pixel_t'(`W_SMALL1);
			Small2: state.sizeX = pixel_t'(`W_SMALL2);
			Small3: state.sizeX = pixel_t'(`W_SMALL3);
			default: state.sizeX = '0;
		endcase
		case (kind)
			Large1: state.base = spriteAddr_t'(`BASE_LARGE1);
			Large2: state.base = spriteAddr_t'(`BASE_LARGE2);
			Large3: state.base = spriteAddr_t'(`BASE_LARGE3);
			Small1: state.base = spriteAddr_t'(`BASE_SMALL1);
			Small2: state.base = spriteAddr_t'(`BASE_SMALL2);
			Small3: state.base = spriteAddr_t'(`BASE_SMALL3);
			default: state.base = '0;
		endcase
	end

	// probability bands: 1/4 1/8 1/8 large, then the same for small
	always_comb
	begin
		case (rnd[5:4])
			2'b00: randKind = Large1;                          // 0..15
			2'b01: randKind = rnd[3] ? Large3 : Large2;        // 16..31
			2'b10: randKind = Small1;                          // 32..47
			default: randKind = rnd[3] ? Small3 : Small2;      // 48..63
		endcase
	end

	assign nextKind = ctrl.suppress ? None : randKind;

	// widen to signed before comparing against posX
	assign sizeXc = coord_t'({1'b0, state.sizeX});
	assign stepX = coord_t'({7'b0, ctrl.speed});
	assign respawn = (posX <= -sizeXc);   // fully off the left edge

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			posX <= coord_t'(`SCREEN_W);
			kind <= None;
		end
		else if (ctrl.run)
		begin
			if (respawn)
			begin
				posX <= coord_t'(`SCREEN_W);
				kind <= nextKind;
			end
			else
				posX <= posX - stepX;
		end
	end

endmodule

// File: hw/kindLfsr.sv
`include "obstacle_defs.svh"

module kindLfsr
	import obstacle_pkg::*;
(
	input logic frame_Clk,
	input logic Reset,
	output lfsr_t value
);

	lfsr_t shifted;

	// galois form, feedback from bit 0 into the taps
	always_comb
	begin
		shifted = value >> 1;
		if (value[0])
			shifted = shifted ^ `LFSR_MASK;
	end

	// free running, independent of the run bit
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			value <= `LFSR_SEED;
		else
			value <= shifted;
	end

endmodule

// File: hw/obstacleTop.sv
module obstacleTop
	import obstacle_pkg::*;
(
	input logic frame_Clk,
	input logic Reset,
	// wishbone classic slave
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [1:0] adr,
	input logic [15:0] datIn,
	output logic ack,
	output logic [15:0] datOut,
	// pixel query port
	input pixQuery_t query,
	output pixResult_t result
);

	ctrl_t ctrl;
	obstacleState_t state;

	wbRegFile regs_i
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.state(state),
		.ack(ack),
		.datOut(datOut),
		.ctrl(ctrl)
	);

	cactusMover mover_i
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.ctrl(ctrl),
		.state(state)
	);

	spriteAddrGen addr_i
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.query(query),
		.state(state),
		.result(result)
	);

endmodule

// File: hw/obstacle_defs.svh
`ifndef OBSTACLE_DEFS_SVH
`define OBSTACLE_DEFS_SVH

// visible screen and the ground rows
`define SCREEN_W      640
`define GROUND_LARGE  320   // top row of a large cactus
`define GROUND_SMALL  350   // top row of a small cactus
`define HIDE_ROW      480   // below the visible area

// sprite heights and widths in pixels
`define LARGE_H       100
`define SMALL_H       70
`define W_LARGE1      50
`define W_LARGE2      100
`define W_LARGE3      150
`define W_SMALL1      36
`define W_SMALL2      68
`define W_SMALL3      102

// start of each sprite in the ROM, row major
`define BASE_LARGE1   0
`define BASE_LARGE2   5000
`define BASE_LARGE3   15000
`define BASE_SMALL1   30000
`define BASE_SMALL2   32520
`define BASE_SMALL3   37280

// kind generator, x^6 + x^5 + 1
`define LFSR_SEED     6'b010101
`define LFSR_MASK     6'h30

`endif

// File: hw/obstacle_pkg.sv
package obstacle_pkg;

	// signed so the cactus can hang off the left edge
	typedef logic signed [10:0] coord_t;
	typedef logic [9:0] pixel_t;
	typedef logic [17:0] spriteAddr_t;
	typedef logic [3:0] speed_t;   // pixels per step
	typedef logic [5:0] lfsr_t;

	typedef enum logic [2:0]
	{
		Large1,
		Large2,
		Large3,
		Small1,
		Small2,
		Small3,
		None
	} cactusKind_t;

	// everything the rest of the engine needs to know about the cactus
	typedef struct packed
	{
		coord_t posX;
		coord_t posY;
		pixel_t sizeX;
		pixel_t sizeY;
		spriteAddr_t base;
		cactusKind_t kind;
	} obstacleState_t;

	typedef struct packed
	{
		logic run;
		logic suppress;   // respawn as None while set
		speed_t speed;
	} ctrl_t;

	typedef struct packed
	{
		logic valid;
		pixel_t x;
		pixel_t y;
	} pixQuery_t;

	typedef struct packed
	{
		logic valid;
		logic on;   // pixel lies inside the sprite
		spriteAddr_t addr;
	} pixResult_t;

endpackage

// File: hw/spriteAddrGen.sv
module spriteAddrGen
	import obstacle_pkg::*;
(
	input logic frame_Clk,
	input logic Reset,
	input pixQuery_t query,
	input obstacleState_t state,
	output pixResult_t result
);

	coord_t qx;
	coord_t qy;
	coord_t distX;
	coord_t distY;
	logic covered;

	// stage 1 registers
	logic valid1;
	logic on1;
	pixel_t col1;
	pixel_t row1;
	pixel_t width1;
	spriteAddr_t base1;

	// stage 2 registers
	logic valid2;
	logic on2;
	spriteAddr_t addr2;

	assign qx = coord_t'({1'b0, query.x});
	assign qy = coord_t'({1'b0, query.y});
	assign distX = qx - state.posX;
	assign distY = qy - state.posY;

	// coverage box test, against the state at query time
	assign covered = (qx >= state.posX)
		&& (qx < state.posX + coord_t'({1'b0, state.sizeX}))
		&& (qy >= state.posY)
		&& (qy < state.posY + coord_t'({1'b0, state.sizeY}))
		&& (state.kind != None);

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			valid1 <= 1'b0;
			valid2 <= 1'b0;
		end
		else
		begin
			valid1 <= query.valid;
			valid2 <= valid1;
		end
	end

	always_ff @(posedge frame_Clk)
	begin
		on1 <= covered;
		col1 <= distX[9:0];   // in range whenever covered
		row1 <= distY[9:0];
		width1 <= state.sizeX;
		base1 <= state.base;
		on2 <= on1;
		if (on1)
			addr2 <= base1 + spriteAddr_t'(row1) * spriteAddr_t'(width1) + spriteAddr_t'(col1);
		else
			addr2 <= '0;
	end

	assign result.valid = valid2;
	assign result.on = on2;
	assign result.addr = addr2;

endmodule

// File: hw/wbRegFile.sv
module wbRegFile
	import obstacle_pkg::*;
(
	input logic frame_Clk,
	input logic Reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [1:0] adr,
	input logic [15:0] datIn,
	input obstacleState_t state,
	output logic ack,
	output logic [15:0] datOut,
	output ctrl_t ctrl
);

	localparam logic [1:0] ADR_CTRL = 2'd0;
	localparam logic [1:0] ADR_POSX = 2'd1;
	localparam logic [1:0] ADR_KIND = 2'd2;

	logic access;   // new bus cycle, not yet acked
	logic wrCtrl;

	assign access = cyc & stb & ~ack;
	assign wrCtrl = access & we & (adr == ADR_CTRL);

	// single cycle ack, one cycle after the request
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			ack <= 1'b0;
		else
			ack <= access;
	end

	// control register, the mover sees the new value after ack
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			ctrl.run <= 1'b0;
			ctrl.suppress <= 1'b0;
			ctrl.speed <= '0;
		end
		else if (wrCtrl)
		begin
			ctrl.run <= datIn[0];
			ctrl.suppress <= datIn[1];
			ctrl.speed <= datIn[7:4];
		end
	end

	// read data straight from the live state
	always_comb
	begin
		datOut = '0;
		case (adr)
			ADR_CTRL:
			begin
				datOut[0] = ctrl.run;
				datOut[1] = ctrl.suppress;
				datOut[7:4] = ctrl.speed;
			end
			ADR_POSX:
				datOut = {{5{state.posX[10]}}, state.posX};   // sign extended
			ADR_KIND:
				datOut[2:0] = state.kind;
			default:
				datOut = '0;
		endcase
	end

endmodule

// File: tests/obstacleChecker.sv
`include "obstacle_defs.svh"

module obstacleChecker
	import obstacle_pkg::*;
(
	input logic frame_Clk,
	input logic Reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [1:0] adr,
	input logic [15:0] datIn,
	input logic ack,
	input logic [15:0] datOut,
	input pixQuery_t query,
	input pixResult_t result,
	input logic [2:0] testId,
	input logic testDone,
	output int errorCount,
	output int checkCount
);

	// indexed by kind, last entry is None
	localparam int WIDTHS [7] = '{`W_LARGE1, `W_LARGE2, `W_LARGE3, `W_SMALL1, `W_SMALL2,
		`W_SMALL3, 0};
	localparam int BASES [7] = '{`BASE_LARGE1, `BASE_LARGE2, `BASE_LARGE3, `BASE_SMALL1,
		`BASE_SMALL2, `BASE_SMALL3, 0};

	string names [6] = '{"", "reset state", "register access", "scrolling", "kind selection",
		"pixel queries"};

	lfsr_t mLfsr;   // mirror of the kind generator
	ctrl_t mCtrl;
	cactusKind_t mKind;
	int mPosX;
	logic mAck;
	logic access;
	logic valid1;
	logic valid2;
	logic [18:0] res1;   // {on, addr}
	logic [18:0] res2;
	int testErrors;

	// quarter and eighth bands, large half then small half
	function automatic cactusKind_t kindFromLfsr(input lfsr_t v, input logic suppress);
		if (suppress)
			return None;
		else if (v < 6'd16)
			return Large1;
		else if (v < 6'd24)
			return Large2;
		else if (v < 6'd32)
			return Large3;
		else if (v < 6'd48)
			return Small1;
		else if (v < 6'd56)
			return Small2;
		return Small3;
	endfunction

	function automatic logic [18:0] pixRef(input int x, input int y, input int posX,
		input cactusKind_t k);
		int w;
		int top;
		int h;
		w = WIDTHS[k];
		top = (k == None) ? `HIDE_ROW : (k <= Large3) ? `GROUND_LARGE : `GROUND_SMALL;
		h = (k == None) ? 0 : (k <= Large3) ? `LARGE_H : `SMALL_H;
		if (x < posX || x >= posX + w || y < top || y >= top + h)
			return '0;
		return {1'b1, 18'(BASES[k] + (y - top) * w + (x - posX))};
	endfunction

	function automatic logic [15:0] readRef(input logic [1:0] a);
		case (a)
			2'd0: return {8'h00, mCtrl.speed, 2'b00, mCtrl.suppress, mCtrl.run};
			2'd1: return 16'(mPosX);   // sign extended
			2'd2: return {13'd0, mKind};
			default: return 16'h0000;
		endcase
	endfunction

	task automatic expectEq(input string what, input int expected, input int actual);
		checkCount++;
		if (expected != actual)
		begin
			errorCount++;
			testErrors++;
			$display("FAIL %s, %s: expected %0d, actual %0d", names[testId], what,
				expected, actual);
		end
	endtask

	always @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			mLfsr = `LFSR_SEED;
			mCtrl = '0;
			mKind = None;
			mPosX = `SCREEN_W;
			mAck = 1'b0;
			valid1 = 1'b0;
			valid2 = 1'b0;
			res1 = '0;
			res2 = '0;
			errorCount = 0;
			checkCount = 0;
			testErrors = 0;
		end
		else
		begin
			// outputs of the cycle ending at this edge
			expectEq("ack", int'(mAck), int'(ack));
			if (mAck && !we)
				expectEq($sformatf("read of register %0d", adr), int'(readRef(adr)),
					int'(datOut));
			expectEq("result valid", int'(valid2), int'(result.valid));
			if (valid2)
				expectEq("pixel result", int'(res2), int'({result.on, result.addr}));
			// queries see the state before this step
			res2 = res1;
			valid2 = valid1;
			res1 = pixRef(int'(query.x), int'(query.y), mPosX, mKind);
			valid1 = query.valid;
			if (mCtrl.run)
			begin
				if (mPosX <= -WIDTHS[mKind])   // fully off the left edge
				begin
					mPosX = `SCREEN_W;
					mKind = kindFromLfsr(mLfsr, mCtrl.suppress);
				end
				else
					mPosX = mPosX - int'(mCtrl.speed);
			end
			access = cyc && stb && !mAck;
			if (access && we && adr == 2'd0)
				mCtrl = ctrl_t'({datIn[0], datIn[1], datIn[7:4]});
			mAck = access;
			mLfsr = mLfsr[0] ? ((mLfsr >> 1) ^ `LFSR_MASK) : (mLfsr >> 1);
			if (testDone)
			begin
				$display("test %0d %s: %0d errors", testId, names[testId], testErrors);
				testErrors = 0;
			end
		end
	end

endmodule

// File: tests/obstacleTop_sva.sv
module obstacleTop_sva
	import obstacle_pkg::*;
(
	input logic frame_Clk,
	input logic Reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input pixQuery_t query,
	input pixResult_t result,
	input ctrl_t ctrl,
	input obstacleState_t state
);

	logic respawn;
	logic suppressedSpawn;   // last respawn happened with suppress set
	int failures = 0;   // failed assertions so far

	assign respawn = ctrl.run && (state.posX <= -coord_t'({1'b0, state.sizeX}));

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			suppressedSpawn <= 1'b1;   // kind leaves reset as None too
		else if (respawn)
			suppressedSpawn <= ctrl.suppress;
	end

	ackInCycle: assert property (@(posedge frame_Clk) disable iff (Reset) ack |-> cyc && stb)
		else
		begin
			failures++;
			$error("ack seen outside a bus cycle");
		end

	ackSingle: assert property (@(posedge frame_Clk) disable iff (Reset) ack |=> !ack)
		else
		begin
			failures++;
			$error("ack lasted two cycles");
		end

	// two stage pipeline, no stalls
	resultLatency: assert property (@(posedge frame_Clk) disable iff (Reset)
		result.valid == $past(query.valid, 2))
		else
		begin
			failures++;
			$error("result valid not two cycles after the query");
		end

	suppressedKind: assert property (@(posedge frame_Clk) disable iff (Reset)
		suppressedSpawn |-> state.kind == None)
		else
		begin
			failures++;
			$error("kind is not None after a suppressed respawn");
		end

endmodule

bind obstacleTop obstacleTop_sva sva_i
(
	.frame_Clk(frame_Clk),
	.Reset(Reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.query(query),
	.result(result),
	.ctrl(ctrl),
	.state(state)
);

// File: tests/tb_obstacle.sv
module tb_obstacle
	import obstacle_pkg::*;
();

	logic frame_Clk;
	logic Reset;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [15:0] datIn;
	logic ack;
	logic [15:0] datOut;
	pixQuery_t query;
	pixResult_t result;
	logic [2:0] testId;
	logic testDone;
	int errorCount;
	int checkCount;
	logic hung;   // some wait ran out
	logic [31:0] randState;
	logic [15:0] rx;
	logic [15:0] ry;

	obstacleTop dut_i
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.ack(ack),
		.datOut(datOut),
		.query(query),
		.result(result)
	);

	obstacleChecker check_i
	(
		.frame_Clk(frame_Clk),
		.Reset(Reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.ack(ack),
		.datOut(datOut),
		.query(query),
		.result(result),
		.testId(testId),
		.testDone(testDone),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	initial
	begin
		frame_Clk = 1'b0;
		forever #4 frame_Clk = ~frame_Clk;
	end

	// x^32 + x^22 + x^2 + x + 1, shifting right
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			randState = galoisStep(randState);
			v = {v[14:0], randState[0]};
		end
	endtask

	task automatic busAccess(input logic write, input logic [1:0] addr,
		input logic [15:0] data);
		int waited;
		waited = 0;
		@(negedge frame_Clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		datIn = data;
		do
		begin
			@(negedge frame_Clk);
			waited++;
		end
		while (!ack && waited < 6);
		if (!ack)
		begin
			$display("no ack within %0d cycles for register %0d", waited, addr);
			hung = 1'b1;
		end
		@(negedge frame_Clk);   // hold past the ack edge
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic queryBurst(input int count);
		int waited;
		waited = 0;
		for (int i = 0; i < count; i++)
		begin
			@(negedge frame_Clk);
			takeBits(10, rx);
			takeBits(7, ry);
			query.valid = 1'b1;
			query.x = rx[9:0];
			query.y = pixel_t'(10'd300 + ry[9:0]);   // rows around the ground
		end
		@(negedge frame_Clk);
		query.valid = 1'b0;
		while (result.valid && waited < 6)
		begin
			@(negedge frame_Clk);
			waited++;
		end
		if (result.valid)
		begin
			$display("result valid still high %0d cycles after the last query", waited);
			hung = 1'b1;
		end
	endtask

	task automatic finishTest();
		@(negedge frame_Clk);
		testDone = 1'b1;
		@(negedge frame_Clk);
		testDone = 1'b0;
	endtask

	initial
	begin
		Reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 2'd0;
		datIn = 16'h0000;
		query = '0;
		testId = 3'd1;
		testDone = 1'b0;
		hung = 1'b0;
		randState = 32'ha2ff;
		repeat (16) @(negedge frame_Clk);
		Reset = 1'b0;

		busAccess(1'b0, 2'd1, 16'h0000);
		busAccess(1'b0, 2'd2, 16'h0000);
		finishTest();

		testId = 3'd2;
		busAccess(1'b1, 2'd0, 16'h0052);   // suppress, speed 5, stopped
		busAccess(1'b0, 2'd0, 16'h0000);
		busAccess(1'b1, 2'd0, 16'h00a1);   // run, speed 10
		busAccess(1'b0, 2'd0, 16'h0000);
		finishTest();

		testId = 3'd3;
		busAccess(1'b1, 2'd0, 16'h0031);   // speed 3
		for (int i = 0; i < 40; i++)
		begin
			repeat (7) @(negedge frame_Clk);
			busAccess(1'b0, 2'd1, 16'h0000);
		end
		finishTest();

		// fast scroll for many respawns
		testId = 3'd4;
		busAccess(1'b1, 2'd0, 16'h00f1);
		for (int i = 0; i < 150; i++)
		begin
			busAccess(1'b0, 2'd2, 16'h0000);
			busAccess(1'b0, 2'd1, 16'h0000);
		end
		busAccess(1'b1, 2'd0, 16'h00f3);
		for (int i = 0; i < 40; i++)
			busAccess(1'b0, 2'd2, 16'h0000);
		finishTest();

		testId = 3'd5;
		busAccess(1'b1, 2'd0, 16'h0041);
		queryBurst(400);
		finishTest();

		$display("%0d checks, %0d errors, %0d assertion failures", checkCount, errorCount,
			dut_i.sva_i.failures);
		if (hung || errorCount != 0 || dut_i.sva_i.failures != 0)
			$display("Testbench failed");
		else
			$display("Testbench passed");
		$finish;
	end

endmodule
